/* hdl/clk_ctrl_pkg.sv */
`default_nettype none

// shared widths for the clock-control block
package clk_ctrl_pkg;

    // width of clk edge counts
    localparam int COUNT_W = 24;

    // raw count or modular difference of two counts
    typedef logic [COUNT_W-1:0] cycle_count_t;

    // synchronizer depth unless the top level says otherwise
    localparam int SYNC_STAGES_DEF = 2;

endpackage : clk_ctrl_pkg

`default_nettype wire

/* hdl/fmeas_pkg.sv */
`default_nettype none

// types of the frequency measurement
package fmeas_pkg;

    localparam int GATE_W = 16;              // gate length width

    // gate window length in pl_clk0 cycles
    typedef logic [GATE_W-1:0] gate_count_t;

    // default gate, 1000 pl_clk0 cycles
    localparam gate_count_t GATE_CYCLES_DEF = gate_count_t'(1000);

    // measurement sequencer states
    typedef enum logic [1:0] {
        IDLE,    // waiting for enable
        GATE,    // gate window open
        DIFF,    // end snapshot taken, subtracting
        RESULT   // result held until handshake
    } fmeas_state_t;

endpackage : fmeas_pkg

`default_nettype wire

/* hdl/cdc_sync.sv */
`timescale 1ns/10ps
`default_nettype none

// single-bit level synchronizer, flop chain starts at INIT
module cdc_sync #(
    parameter int SYNC_STAGES = clk_ctrl_pkg::SYNC_STAGES_DEF,
    parameter bit INIT        = 1'b0
) (
    input  wire  dest_clk,
    input  wire  din,        // asynchronous level
    output logic dout        // dest_clk domain
);

    // chain comes up at INIT
    logic [SYNC_STAGES-1:0] sync_q = {SYNC_STAGES{INIT}};

    always_ff @(posedge dest_clk) begin
        sync_q <= {sync_q[SYNC_STAGES-2:0], din};  // bit 0 is the metastable stage
    end

    assign dout = sync_q[SYNC_STAGES-1];

    // fewer than two stages is no synchronizer
    if (SYNC_STAGES < 2) begin : g_stage_chk
        $error("cdc_sync needs at least 2 stages, got %0d", SYNC_STAGES);
    end

endmodule : cdc_sync

`default_nettype wire

/* hdl/gate_timer.sv */
`timescale 1ns/10ps
`default_nettype none

// gate window timer, counts GATE_CYCLES pl_clk0 cycles
module gate_timer #(
    parameter fmeas_pkg::gate_count_t GATE_CYCLES = fmeas_pkg::GATE_CYCLES_DEF
) (
    input  wire  pl_clk0,
    input  wire  rst_n,
    input  wire  timer_start,   // one-cycle launch pulse
    output logic timer_done     // one-cycle pulse, GATE_CYCLES after start
);

    import fmeas_pkg::*;

    gate_count_t count;   // cycles left minus one
    logic        running;

    always_ff @(posedge pl_clk0) begin
        if (!rst_n) begin
            running <= 1'b0;
            count   <= '0;
        end else if (timer_start) begin
            running <= 1'b1;
            count   <= GATE_CYCLES - gate_count_t'(1);   // done shows in the last cycle
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;    // back to idle after the pulse
            end else begin
                count <= count - gate_count_t'(1);
            end
        end
    end

    // terminal count decode, high for exactly one cycle
    assign timer_done = running && (count == '0);

    // sequencer must wait for the previous gate to end
    a_no_restart: assert property (
        @(posedge pl_clk0) disable iff (!rst_n)
        timer_start |-> !running
    ) else $error("gate_timer restarted while running");

endmodule : gate_timer

`default_nettype wire

/* hdl/test_clk_counter.sv */
`timescale 1ns/10ps
`default_nettype none

// counts test_clk edges and hands the count to pl_clk0 as gray code
module test_clk_counter #(
    parameter int SYNC_STAGES = clk_ctrl_pkg::SYNC_STAGES_DEF
) (
    input  wire                         test_clk,
    input  wire                         test_reset,   // test_clk domain, active high
    input  wire                         pl_clk0,
    input  wire                         rst_n,
    output clk_ctrl_pkg::cycle_count_t  snap_count    // pl_clk0 domain, binary
);

    import clk_ctrl_pkg::*;

    cycle_count_t bin_q;      // free-running binary count
    cycle_count_t gray_q;     // registered gray, the only crossing signal
    cycle_count_t gray_sync [SYNC_STAGES] = '{default: '0};
    cycle_count_t gray_bin;   // decoded, before the output flop

    // test_clk side
    always_ff @(posedge test_clk) begin
        if (test_reset) begin
            bin_q  <= '0;     // held at zero while the clock is not trusted
            gray_q <= '0;
        end else begin
            bin_q  <= bin_q + cycle_count_t'(1);
            gray_q <= bin_q ^ (bin_q >> 1);   // one bit flips per edge
        end
    end

    // pl_clk0 side, one flop chain per bit
    always_ff @(posedge pl_clk0) begin
        gray_sync[0] <= gray_q;
        for (int s = 1; s < SYNC_STAGES; s++) begin
            gray_sync[s] <= gray_sync[s-1];
        end
    end

    // gray to binary, msb down
    always_comb begin
        gray_bin[COUNT_W-1] = gray_sync[SYNC_STAGES-1][COUNT_W-1];
        for (int i = COUNT_W - 2; i >= 0; i--) begin
            gray_bin[i] = gray_bin[i+1] ^ gray_sync[SYNC_STAGES-1][i];
        end
    end

    always_ff @(posedge pl_clk0) begin
        if (!rst_n) begin
            snap_count <= '0;
        end else begin
            snap_count <= gray_bin;   // total lag SYNC_STAGES+2 edges
        end
    end

    // a multi-bit jump would be sampled as garbage on the far side
    a_gray_step: assert property (
        @(posedge test_clk) disable iff (test_reset)
        $countones(gray_q ^ $past(gray_q)) <= 1
    ) else $error("gray count changed more than one bit");

endmodule : test_clk_counter

`default_nettype wire

/* hdl/fmeas_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

// measurement sequencer, snapshot, subtract, hold under valid/ready
module fmeas_fsm (
    input  wire                         pl_clk0,
    input  wire                         rst_n,
    input  wire                         fmeas_enable,   // level request
    input  wire clk_ctrl_pkg::cycle_count_t snap_count, // synchronized clk count
    output logic                        timer_start,
    input  wire                         timer_done,
    output logic                        fmeas_valid,
    input  wire                         fmeas_ready,
    output clk_ctrl_pkg::cycle_count_t  fmeas_count
);

    import clk_ctrl_pkg::*;
    import fmeas_pkg::*;

    fmeas_state_t state;
    logic         draining;    // aborted gate still running in the timer
    cycle_count_t start_q;
    cycle_count_t end_q;
    cycle_count_t count_q;     // held result

    always_ff @(posedge pl_clk0) begin
        if (!rst_n) begin
            state       <= IDLE;
            timer_start <= 1'b0;
            draining    <= 1'b0;
        end else begin
            timer_start <= 1'b0;              // pulse by default
            if (timer_done) begin
                draining <= 1'b0;             // timer is idle again
            end
            case (state)
                IDLE: begin
                    if (fmeas_enable && !draining) begin
                        timer_start <= 1'b1;
                        state       <= GATE;
                    end
                end
                GATE: begin
                    if (timer_done) begin
                        state <= DIFF;
                    end else if (!fmeas_enable) begin
                        state    <= IDLE;     // abort, no result
                        draining <= 1'b1;
                    end
                end
                DIFF:   state <= RESULT;
                RESULT: begin
                    if (fmeas_ready) begin
                        state <= IDLE;        // transferred
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // snapshots and difference
    always_ff @(posedge pl_clk0) begin
        if (timer_start) begin
            start_q <= snap_count;    // taken with the timer launch, window is GATE_CYCLES edges
        end
        if (state == GATE && timer_done) begin
            end_q <= snap_count;
        end
        if (state == DIFF) begin
            count_q <= end_q - start_q;   // wraps mod 2^COUNT_W
        end
    end

    assign fmeas_valid = (state == RESULT);
    assign fmeas_count = count_q;

    // result must not move before the transfer
    a_hold: assert property (
        @(posedge pl_clk0) disable iff (!rst_n)
        fmeas_valid && !fmeas_ready |=> fmeas_valid && $stable(fmeas_count)
    ) else $error("fmeas result changed under back-pressure");

    // done only belongs to a live gate or one being drained after abort
    a_done_state: assert property (
        @(posedge pl_clk0) disable iff (!rst_n)
        timer_done |-> (state == GATE) || draining
    ) else $error("timer_done outside a gate");

endmodule : fmeas_fsm

`default_nettype wire

/* hdl/clk_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

// clock control, lock and reset crossing, clk frequency measurement
module clk_ctrl #(
    parameter fmeas_pkg::gate_count_t GATE_CYCLES = fmeas_pkg::GATE_CYCLES_DEF,
    parameter int                     SYNC_STAGES = clk_ctrl_pkg::SYNC_STAGES_DEF
) (
    // processor side
    input  wire                         pl_clk0,
    input  wire                         rst_n,          // pl_clk0 domain
    input  wire                         sys_reset,      // pl_clk0 domain, resets clk logic

    // clocking block
    input  wire                         clkwiz_clkout0,
    input  wire                         clkwiz_locked,

    // to the design
    output logic                        clk,
    output logic                        reset,          // clk domain, active high

    output logic                        clk_locked,     // pl_clk0 domain

    // measurement, pl_clk0 domain
    input  wire                         fmeas_enable,
    input  wire                         fmeas_ready,
    output logic                        fmeas_valid,
    output clk_ctrl_pkg::cycle_count_t  fmeas_count
);

    import clk_ctrl_pkg::*;

    logic         sys_reset_synced;   // clk domain
    cycle_count_t snap_count;         // pl_clk0 domain
    logic         timer_start;
    logic         timer_done;

    assign clk = clkwiz_clkout0;      // straight through, no buffer here

    // lock flag into the processor domain
    cdc_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .INIT        (1'b0)          // not locked until seen
    ) locked_sync (
        .dest_clk (pl_clk0),
        .din      (clkwiz_locked),
        .dout     (clk_locked)
    );

    // processor reset into the design clock domain
    cdc_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .INIT        (1'b1)          // design held in reset at power-up
    ) sys_reset_sync (
        .dest_clk (clk),
        .din      (sys_reset),
        .dout     (sys_reset_synced)
    );

    // lock loss resets at once, sys_reset arrives synchronized
    assign reset = !clkwiz_locked || sys_reset_synced;

    test_clk_counter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) fmeas_counter (
        .test_clk   (clk),
        .test_reset (reset),
        .pl_clk0    (pl_clk0),
        .rst_n      (rst_n),
        .snap_count (snap_count)
    );

    gate_timer #(
        .GATE_CYCLES (GATE_CYCLES)
    ) fmeas_timer (
        .pl_clk0     (pl_clk0),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    fmeas_fsm fmeas_ctrl (
        .pl_clk0      (pl_clk0),
        .rst_n        (rst_n),
        .fmeas_enable (fmeas_enable),
        .snap_count   (snap_count),
        .timer_start  (timer_start),
        .timer_done   (timer_done),
        .fmeas_valid  (fmeas_valid),
        .fmeas_ready  (fmeas_ready),
        .fmeas_count  (fmeas_count)
    );

endmodule : clk_ctrl

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// processor clock and its synchronous reset
module tb_clk_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic pl_clk0,
    output logic rst_n
);

    initial begin
        pl_clk0 = 1'b0;
        forever #(PERIOD_NS / 2.0) pl_clk0 = ~pl_clk0;
    end

    initial begin
        rst_n = 1'b0;                              // low from time zero
        repeat (RESET_CYCLES) @(posedge pl_clk0);
        rst_n <= 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* test/tb_clk_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_ctrl;

    import clk_ctrl_pkg::*;

    localparam int GATE           = 200;
    localparam int LATENCY        = GATE + 2;               // sampled enable to valid
    localparam int TIMEOUT_CYCLES = 8 * (GATE + 50) + 500;

    logic         pl_clk0;
    logic         rst_n;
    logic         sys_reset;
    logic         clkwiz_clkout0;
    logic         clkwiz_locked;
    logic         fmeas_enable;
    logic         fmeas_ready;
    logic         clk;
    logic         reset;
    logic         clk_locked;
    logic         fmeas_valid;
    cycle_count_t fmeas_count;

    real clk_period   = 20.0;    // clocking block output period in ns
    int  errors       = 0;
    int  tests_failed = 0;
    int  cycle_cnt    = 0;

    tb_clk_gen #(.PERIOD_NS(20.0), .RESET_CYCLES(3)) pl_gen (
        .pl_clk0 (pl_clk0),
        .rst_n   (rst_n)
    );

    clk_ctrl #(
        .GATE_CYCLES (fmeas_pkg::gate_count_t'(GATE))
    ) u_clk_ctrl (
        .pl_clk0        (pl_clk0),
        .rst_n          (rst_n),
        .sys_reset      (sys_reset),
        .clkwiz_clkout0 (clkwiz_clkout0),
        .clkwiz_locked  (clkwiz_locked),
        .clk            (clk),
        .reset          (reset),
        .clk_locked     (clk_locked),
        .fmeas_enable   (fmeas_enable),
        .fmeas_ready    (fmeas_ready),
        .fmeas_valid    (fmeas_valid),
        .fmeas_count    (fmeas_count)
    );

    // clocking block model, period follows clk_period
    initial begin
        clkwiz_clkout0 = 1'b0;
        #3;                                         // keep edges off the pl_clk0 edges
        forever #(clk_period / 2.0) clkwiz_clkout0 = ~clkwiz_clkout0;
    end

    always @(posedge pl_clk0) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, a test hung", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_value_error(string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_fault(string msg);
        $display("at %0t ns %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(string name, int err0);
        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %-13s %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    task automatic wait_locked(output bit seen);
        seen = 1'b0;
        repeat (3) begin                            // 3 pl_clk0 edges
            @(posedge pl_clk0);
            @(negedge pl_clk0);
            seen |= clk_locked;
        end
    endtask

    task automatic wait_reset_level(input logic level, output bit seen);
        seen = 1'b0;
        repeat (3) begin                            // 3 clk edges
            @(posedge clk);
            @(negedge clk);
            seen |= (reset == level);
        end
    endtask

    // design clock is the clocking block output, no delay
    task automatic check_clk_passthrough();
        repeat (4) begin
            @(clkwiz_clkout0);
            #1;
            assert (clk === clkwiz_clkout0)
                else report_value_error("clk does not follow clkwiz_clkout0");
        end
    endtask

    // one enable-to-valid run, leaves enable low on return
    task automatic run_measurement(output cycle_count_t result);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge pl_clk0);
        fmeas_enable <= 1'b1;
        while (!seen && cycles < GATE + 50) begin
            @(posedge pl_clk0);
            cycles++;                               // first edge samples enable
            @(negedge pl_clk0);
            seen = fmeas_valid;
        end
        result = fmeas_count;
        assert (seen) else report_fault("no fmeas_valid after the gate window");
        assert (!seen || cycles - 1 >= LATENCY)
            else report_fault($sformatf("fmeas_valid came too early, %0d cycles", cycles - 1));
        assert (!seen || cycles - 1 <= LATENCY)
            else report_fault($sformatf("fmeas_valid came late, %0d cycles", cycles - 1));
        @(posedge pl_clk0);
        fmeas_enable <= 1'b0;                       // transfer edge when ready is high
    endtask

    task automatic check_count(cycle_count_t result, real period);
        int expected;
        int diff;
        expected = int'(GATE * 20.0 / period);      // gate time over clk period
        diff     = int'(result) - expected;
        assert (diff >= -2 && diff <= 2)
            else report_value_error($sformatf("count %0d at %0.1f ns period, expected %0d",
                                              result, period, expected));
    endtask

    task automatic measure_at(real period);
        cycle_count_t result;
        clk_period = period;
        repeat (10) @(posedge pl_clk0);             // new period settles
        check_clk_passthrough();
        run_measurement(result);
        check_count(result, period);
        @(negedge pl_clk0);
        assert (!fmeas_valid) else report_fault("fmeas_valid stayed high after the transfer");
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        @(posedge pl_clk0);
        while (!rst_n) begin
            @(posedge pl_clk0);
        end
        @(negedge pl_clk0);
        assert (!fmeas_valid) else report_value_error("fmeas_valid high after reset");
        assert (!clk_locked) else report_value_error("clk_locked high with lock low");
        assert (reset) else report_value_error("reset low with lock low");
        close_test("reset state", err0);
    endtask

    task automatic test_lock_path();
        bit lock_seen;
        bit rst_seen;
        int err0;
        err0 = errors;
        @(posedge pl_clk0);
        clkwiz_locked <= 1'b1;
        fork
            wait_locked(lock_seen);
            wait_reset_level(1'b0, rst_seen);
        join
        assert (lock_seen) else report_fault("clk_locked did not rise within 3 pl_clk0 edges");
        assert (rst_seen) else report_fault("reset did not fall within 3 clk edges of lock");
        @(posedge pl_clk0);
        sys_reset <= 1'b1;
        wait_reset_level(1'b1, rst_seen);
        assert (rst_seen) else report_fault("reset did not follow sys_reset within 3 clk edges");
        @(posedge pl_clk0);
        sys_reset <= 1'b0;                          // release for the measurements
        wait_reset_level(1'b0, rst_seen);
        assert (rst_seen) else report_fault("reset did not release after sys_reset fell");
        close_test("lock path", err0);
    endtask

    task automatic test_frequency();
        int err0;
        err0 = errors;
        measure_at(20.0);
        measure_at(14.0);
        measure_at(50.0);
        close_test("frequency", err0);
    endtask

    task automatic test_back_pressure();
        cycle_count_t held;
        int           err0;
        err0 = errors;
        @(posedge pl_clk0);
        fmeas_ready <= 1'b0;
        run_measurement(held);
        repeat (30) begin
            @(negedge pl_clk0);
            assert (fmeas_valid && fmeas_count == held)
                else report_value_error("result moved while ready was low");
            @(posedge pl_clk0);
        end
        fmeas_ready <= 1'b1;
        @(negedge pl_clk0);
        assert (fmeas_valid && fmeas_count == held)
            else report_value_error("result lost before the transfer");
        @(negedge pl_clk0);                         // transfer edge has passed
        assert (!fmeas_valid) else report_fault("fmeas_valid did not fall after the transfer");
        check_count(held, clk_period);
        close_test("back-pressure", err0);
    endtask

    task automatic test_unlocked();
        cycle_count_t result;
        int           err0;
        err0 = errors;
        @(posedge pl_clk0);
        clkwiz_locked <= 1'b0;
        repeat (10) @(posedge pl_clk0);             // zero count through the sync chain
        run_measurement(result);
        assert (result == '0)
            else report_value_error($sformatf("unlocked count %0d, expected 0", result));
        @(posedge pl_clk0);
        clkwiz_locked <= 1'b1;
        close_test("unlocked", err0);
    endtask

    task automatic test_abort();
        bit seen;
        int err0;
        err0 = errors;
        seen = 1'b0;
        @(posedge pl_clk0);
        fmeas_enable <= 1'b1;
        repeat (GATE / 2) @(posedge pl_clk0);
        fmeas_enable <= 1'b0;                       // halfway through the gate
        repeat (GATE + 20) begin
            @(negedge pl_clk0);
            seen |= fmeas_valid;
        end
        assert (!seen) else report_fault("fmeas_valid appeared after an aborted gate");
        close_test("abort", err0);
    endtask

    initial begin
        sys_reset     = 1'b0;
        clkwiz_locked = 1'b0;
        fmeas_enable  = 1'b0;
        fmeas_ready   = 1'b1;                       // sink ready unless a test holds it off
        test_reset_state();
        test_lock_path();
        test_frequency();
        test_back_pressure();
        test_unlocked();
        test_abort();
        $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_clk_ctrl

`default_nettype wire

/* src.f */
hdl/clk_ctrl_pkg.sv
hdl/fmeas_pkg.sv
hdl/cdc_sync.sv
hdl/gate_timer.sv
hdl/test_clk_counter.sv
hdl/fmeas_fsm.sv
hdl/clk_ctrl.sv
test/tb_clk_gen.sv
test/tb_clk_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the clk_ctrl testbench, pass only if the pass message shows up
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_clk_ctrl -f src.f \
    && ./obj_dir/Vtb_clk_ctrl | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
